/* design/sigmoidPkg.sv */
package sigmoidPkg;

    // scores and activations
    localparam int dataWidth = 8;

    // buffer geometry
    localparam int numRows = 64;
    localparam int resCols = 2;
    localparam int sigCols = 3;
    localparam int resAddrWidth = 7;
    localparam int sigAddrWidth = 8;
    localparam int rowWidth = 6;

    // first byte of every SIG row
    localparam logic [dataWidth-1:0] biasValue = 8'd255;

    // ends of the activation curve
    localparam logic [dataWidth-1:0] lutMin = 8'd12;
    localparam logic [dataWidth-1:0] lutMax = 8'd243;

    // one-hot sequencer states
    localparam int seqStateWidth = 5;
    localparam logic [seqStateWidth-1:0] seqIdle = 5'b00001;
    localparam logic [seqStateWidth-1:0] seqWriteBias = 5'b00010;
    localparam logic [seqStateWidth-1:0] seqWriteAct0 = 5'b00100;
    localparam logic [seqStateWidth-1:0] seqWriteAct1 = 5'b01000;
    localparam logic [seqStateWidth-1:0] seqFinish = 5'b10000;

endpackage

/* design/sigmoidLut.sv */
`timescale 1ns/10ps

module sigmoidLut (
    input  logic [sigmoidPkg::dataWidth-1:0] score,
    output logic [sigmoidPkg::dataWidth-1:0] actValue
);
    import sigmoidPkg::*;

    // one range per output step, curve is monotonic
    always_comb begin
        case (score) inside
            [0:3]:     actValue = lutMin;
            [4:6]:     actValue = 8'd13;
            [7:9]:     actValue = 8'd14;
            [10:12]:   actValue = 8'd15;
            [13:15]:   actValue = 8'd16;
            [16:17]:   actValue = 8'd17;
            [18:20]:   actValue = 8'd18;
            [21:22]:   actValue = 8'd19;
            [23:24]:   actValue = 8'd20;
            [25:27]:   actValue = 8'd21;
            [28:29]:   actValue = 8'd22;
            [30:31]:   actValue = 8'd23;
            [32:33]:   actValue = 8'd24;
            [34:34]:   actValue = 8'd25;
            [35:36]:   actValue = 8'd26;
            [37:38]:   actValue = 8'd27;
            [39:40]:   actValue = 8'd28;
            [41:41]:   actValue = 8'd29;
            [42:43]:   actValue = 8'd30;
            [44:44]:   actValue = 8'd31;
            [45:46]:   actValue = 8'd32;
            [47:47]:   actValue = 8'd33;
            [48:49]:   actValue = 8'd34;
            [50:50]:   actValue = 8'd35;
            [51:52]:   actValue = 8'd36;
            [53:53]:   actValue = 8'd37;
            [54:54]:   actValue = 8'd38;
            [55:56]:   actValue = 8'd39;
            [57:57]:   actValue = 8'd40;
            [58:58]:   actValue = 8'd41;
            [59:59]:   actValue = 8'd42;
            [60:60]:   actValue = 8'd43;
            [61:62]:   actValue = 8'd44;
            [63:63]:   actValue = 8'd45;
            // steep middle of the curve
            [64:64]:   actValue = 8'd46;
            [65:65]:   actValue = 8'd47;
            [66:66]:   actValue = 8'd48;
            [67:67]:   actValue = 8'd49;
            [68:68]:   actValue = 8'd50;
            [69:69]:   actValue = 8'd51;
            [70:70]:   actValue = 8'd52;
            [71:71]:   actValue = 8'd53;
            [72:72]:   actValue = 8'd54;
            [73:73]:   actValue = 8'd55;
            [74:74]:   actValue = 8'd56;
            [75:75]:   actValue = 8'd57;
            [76:76]:   actValue = 8'd58;
            [77:77]:   actValue = 8'd59;
            [78:78]:   actValue = 8'd60;
            [79:79]:   actValue = 8'd61;
            [80:80]:   actValue = 8'd62;
            [81:81]:   actValue = 8'd63;
            [82:82]:   actValue = 8'd64;
            [83:83]:   actValue = 8'd66;
            [84:84]:   actValue = 8'd67;
            [85:85]:   actValue = 8'd68;
            [86:86]:   actValue = 8'd69;
            [87:87]:   actValue = 8'd70;
            [88:88]:   actValue = 8'd72;
            [89:89]:   actValue = 8'd73;
            [90:90]:   actValue = 8'd74;
            [91:91]:   actValue = 8'd75;
            [92:92]:   actValue = 8'd76;
            [93:93]:   actValue = 8'd78;
            [94:94]:   actValue = 8'd79;
            [95:95]:   actValue = 8'd80;
            [96:96]:   actValue = 8'd82;
            [97:97]:   actValue = 8'd83;
            [98:98]:   actValue = 8'd84;
            [99:99]:   actValue = 8'd86;
            [100:100]: actValue = 8'd87;
            [101:101]: actValue = 8'd88;
            [102:102]: actValue = 8'd90;
            [103:103]: actValue = 8'd91;
            [104:104]: actValue = 8'd92;
            [105:105]: actValue = 8'd94;
            [106:106]: actValue = 8'd95;
            [107:107]: actValue = 8'd97;
            [108:108]: actValue = 8'd98;
            [109:109]: actValue = 8'd99;
            [110:110]: actValue = 8'd101;
            [111:111]: actValue = 8'd102;
            [112:112]: actValue = 8'd104;
            [113:113]: actValue = 8'd105;
            [114:114]: actValue = 8'd107;
            [115:115]: actValue = 8'd108;
            [116:116]: actValue = 8'd110;
            [117:117]: actValue = 8'd111;
            [118:118]: actValue = 8'd113;
            [119:119]: actValue = 8'd114;
            [120:120]: actValue = 8'd116;
            [121:121]: actValue = 8'd117;
            [122:122]: actValue = 8'd119;
            [123:123]: actValue = 8'd120;
            [124:124]: actValue = 8'd122;
            [125:125]: actValue = 8'd123;
            [126:126]: actValue = 8'd125;
            [127:127]: actValue = 8'd126;
            [128:128]: actValue = 8'd128;
            [129:129]: actValue = 8'd129;
            [130:130]: actValue = 8'd130;
            [131:131]: actValue = 8'd132;
            [132:132]: actValue = 8'd133;
            [133:133]: actValue = 8'd135;
            [134:134]: actValue = 8'd136;
            [135:135]: actValue = 8'd138;
            [136:136]: actValue = 8'd139;
            [137:137]: actValue = 8'd141;
            [138:138]: actValue = 8'd142;
            [139:139]: actValue = 8'd144;
            [140:140]: actValue = 8'd145;
            [141:141]: actValue = 8'd147;
            [142:142]: actValue = 8'd148;
            [143:143]: actValue = 8'd150;
            [144:144]: actValue = 8'd151;
            [145:145]: actValue = 8'd153;
            [146:146]: actValue = 8'd154;
            [147:147]: actValue = 8'd156;
            [148:148]: actValue = 8'd157;
            [149:149]: actValue = 8'd158;
            [150:150]: actValue = 8'd160;
            [151:151]: actValue = 8'd161;
            [152:152]: actValue = 8'd163;
            [153:153]: actValue = 8'd164;
            [154:154]: actValue = 8'd165;
            [155:155]: actValue = 8'd167;
            [156:156]: actValue = 8'd168;
            [157:157]: actValue = 8'd169;
            [158:158]: actValue = 8'd171;
            [159:159]: actValue = 8'd172;
            [160:160]: actValue = 8'd173;
            [161:161]: actValue = 8'd175;
            [162:162]: actValue = 8'd176;
            [163:163]: actValue = 8'd177;
            [164:164]: actValue = 8'd179;
            [165:165]: actValue = 8'd180;
            [166:166]: actValue = 8'd181;
            [167:167]: actValue = 8'd182;
            [168:168]: actValue = 8'd183;
            [169:169]: actValue = 8'd185;
            [170:170]: actValue = 8'd186;
            [171:171]: actValue = 8'd187;
            [172:172]: actValue = 8'd188;
            [173:173]: actValue = 8'd189;
            [174:174]: actValue = 8'd191;
            [175:175]: actValue = 8'd192;
            [176:176]: actValue = 8'd193;
            [177:177]: actValue = 8'd194;
            [178:178]: actValue = 8'd195;
            [179:179]: actValue = 8'd196;
            [180:180]: actValue = 8'd197;
            [181:181]: actValue = 8'd198;
            [182:182]: actValue = 8'd199;
            [183:183]: actValue = 8'd200;
            [184:184]: actValue = 8'd201;
            [185:185]: actValue = 8'd202;
            [186:186]: actValue = 8'd203;
            [187:187]: actValue = 8'd204;
            [188:188]: actValue = 8'd205;
            [189:189]: actValue = 8'd206;
            [190:190]: actValue = 8'd207;
            [191:191]: actValue = 8'd208;
            [192:192]: actValue = 8'd209;
            [193:193]: actValue = 8'd210;
            // upper knee flattens out
            [194:195]: actValue = 8'd211;
            [196:196]: actValue = 8'd212;
            [197:197]: actValue = 8'd213;
            [198:198]: actValue = 8'd214;
            [199:199]: actValue = 8'd215;
            [200:201]: actValue = 8'd216;
            [202:202]: actValue = 8'd217;
            [203:203]: actValue = 8'd218;
            [204:205]: actValue = 8'd219;
            [206:206]: actValue = 8'd220;
            [207:208]: actValue = 8'd221;
            [209:209]: actValue = 8'd222;
            [210:211]: actValue = 8'd223;
            [212:212]: actValue = 8'd224;
            [213:214]: actValue = 8'd225;
            [215:215]: actValue = 8'd226;
            [216:217]: actValue = 8'd227;
            [218:219]: actValue = 8'd228;
            [220:221]: actValue = 8'd229;
            [222:222]: actValue = 8'd230;
            [223:224]: actValue = 8'd231;
            [225:226]: actValue = 8'd232;
            [227:228]: actValue = 8'd233;
            [229:231]: actValue = 8'd234;
            [232:233]: actValue = 8'd235;
            [234:235]: actValue = 8'd236;
            [236:238]: actValue = 8'd237;
            [239:240]: actValue = 8'd238;
            [241:243]: actValue = 8'd239;
            [244:246]: actValue = 8'd240;
            [247:249]: actValue = 8'd241;
            [250:252]: actValue = 8'd242;
            // 253 and above saturate
            default:   actValue = lutMax;
        endcase
    end

endmodule

/* design/sigmoidSequencer.sv */
`timescale 1ns/10ps

module sigmoidSequencer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                startSigmoid,
    input  logic [sigmoidPkg::dataWidth-1:0]    actValue,
    output logic                                sigmoidDone,
    output logic                                resReadEn,
    output logic [sigmoidPkg::resAddrWidth-1:0] resAddr,
    output logic                                sigWriteEn,
    output logic [sigmoidPkg::sigAddrWidth-1:0] sigAddr,
    output logic [sigmoidPkg::dataWidth-1:0]    sigData
);
    import sigmoidPkg::*;

    logic [seqStateWidth-1:0] state;
    logic [rowWidth-1:0]      row;
    logic [resAddrWidth-1:0]  resBase;
    logic [sigAddrWidth-1:0]  sigBase;
    logic                     lastRow;

    assign lastRow = (row == rowWidth'(numRows - 1));

    // state names the SIG byte currently on the write port
    assign sigWriteEn = |(state & (seqWriteBias | seqWriteAct0 | seqWriteAct1));
    assign sigmoidDone = (state == seqWriteAct1) && lastRow;

    // scores are fetched one cycle ahead of their write
    assign resReadEn = |(state & (seqWriteBias | seqWriteAct0));
    assign resAddr = (state == seqWriteAct0) ? resBase + resAddrWidth'(1) : resBase;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= seqIdle;
            row <= '0;
            resBase <= '0;
            sigBase <= '0;
        end else begin
            case (state)
                seqIdle: begin
                    if (startSigmoid) begin
                        state <= seqWriteBias;
                        row <= '0;
                        resBase <= '0;
                        sigBase <= '0;
                    end
                end
                seqWriteBias: begin
                    state <= seqWriteAct0;
                end
                seqWriteAct0: begin
                    state <= seqWriteAct1;
                end
                seqWriteAct1: begin
                    if (lastRow) begin
                        state <= seqFinish;
                    end else begin
                        state <= seqWriteBias;
                        row <= row + rowWidth'(1);
                        resBase <= resBase + resAddrWidth'(resCols);
                        sigBase <= sigBase + sigAddrWidth'(sigCols);
                    end
                end
                // recovery cycle, start not yet taken
                seqFinish: begin
                    state <= seqIdle;
                end
                default: begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    // next write byte and its address
    always_ff @(posedge clk) begin
        case (state)
            seqIdle: begin
                sigData <= biasValue;
                sigAddr <= '0;
            end
            seqWriteBias: begin
                sigData <= actValue;
                sigAddr <= sigBase + sigAddrWidth'(1);
            end
            seqWriteAct0: begin
                sigData <= actValue;
                sigAddr <= sigBase + sigAddrWidth'(2);
            end
            seqWriteAct1: begin
                // bias of the following row
                sigData <= biasValue;
                sigAddr <= sigBase + sigAddrWidth'(sigCols);
            end
            default: begin
                sigData <= sigData;
                sigAddr <= sigAddr;
            end
        endcase
    end

endmodule

/* design/sigmoidUnit.sv */
`timescale 1ns/10ps

module sigmoidUnit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                startSigmoid,
    input  logic [sigmoidPkg::dataWidth-1:0]    resData,
    output logic                                sigmoidDone,
    output logic                                resReadEn,
    output logic [sigmoidPkg::resAddrWidth-1:0] resAddr,
    output logic                                sigWriteEn,
    output logic [sigmoidPkg::sigAddrWidth-1:0] sigAddr,
    output logic [sigmoidPkg::dataWidth-1:0]    sigData
);
    import sigmoidPkg::*;

    // sigmoid of the score currently on the RES read port
    logic [dataWidth-1:0] actValue;

    sigmoidLut lut (
        .score    (resData),
        .actValue (actValue)
    );

    sigmoidSequencer seq (
        .clk          (clk),
        .rst          (rst),
        .startSigmoid (startSigmoid),
        .actValue     (actValue),
        .sigmoidDone  (sigmoidDone),
        .resReadEn    (resReadEn),
        .resAddr      (resAddr),
        .sigWriteEn   (sigWriteEn),
        .sigAddr      (sigAddr),
        .sigData      (sigData)
    );

endmodule

/* sim/sigmoidUnit_assertions.sv */
`timescale 1ns/10ps

module sigmoidUnit_assertions (
    input logic                                 clk,
    input logic                                 rst,
    input logic                                 startSigmoid,
    input logic                                 sigmoidDone,
    input logic                                 resReadEn,
    input logic [sigmoidPkg::resAddrWidth-1:0]  resAddr,
    input logic                                 sigWriteEn,
    input logic [sigmoidPkg::sigAddrWidth-1:0]  sigAddr,
    input logic [sigmoidPkg::seqStateWidth-1:0] seqState
);
    import sigmoidPkg::*;

    int writesSoFar;
    int assertFailures = 0;

    // writes seen in the current run, before this cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            writesSoFar <= 0;
        end else if (sigWriteEn) begin
            writesSoFar <= sigmoidDone ? 0 : writesSoFar + 1;
        end
    end

    resetQuiet: assert property (@(posedge clk) rst |=> !sigWriteEn && !resReadEn && !sigmoidDone)
        else begin
            $error("strobes or done active right after reset");
            assertFailures++;
        end

    donePulse: assert property (@(posedge clk) disable iff (rst) sigmoidDone |=> !sigmoidDone)
        else begin
            $error("done held for more than one cycle");
            assertFailures++;
        end

    // done comes with write 192 of the run, at the last SIG address
    doneOnLast: assert property (@(posedge clk) disable iff (rst)
        sigmoidDone |-> sigWriteEn && (sigAddr == sigAddrWidth'(numRows * sigCols - 1))
            && (writesSoFar == numRows * sigCols - 1))
        else begin
            $error("done not on the last write of the run");
            assertFailures++;
        end

    writeStream: assert property (@(posedge clk) disable iff (rst)
        (sigWriteEn && !sigmoidDone)
            |=> sigWriteEn && (sigAddr == $past(sigAddr) + sigAddrWidth'(1)))
        else begin
            $error("write stream broken or SIG address not consecutive");
            assertFailures++;
        end

    firstWrite: assert property (@(posedge clk) disable iff (rst)
        (seqState == seqIdle && startSigmoid) |=> sigWriteEn && (sigAddr == '0))
        else begin
            $error("accepted start not followed by a write to address 0");
            assertFailures++;
        end

    busyStart: assert property (@(posedge clk) disable iff (rst)
        (seqState != seqIdle && startSigmoid) |=> !(sigWriteEn && (sigAddr == '0)))
        else begin
            $error("start taken while a run was busy");
            assertFailures++;
        end

    // each score read feeds the SIG write of the following cycle
    readAhead: assert property (@(posedge clk) disable iff (rst)
        resReadEn |=> sigWriteEn
            && (sigAddr == sigAddrWidth'(sigCols * ($past(resAddr) / resCols)
                + 1 + $past(resAddr) % resCols)))
        else begin
            $error("RES address does not match the SIG write that follows it");
            assertFailures++;
        end

endmodule

bind sigmoidUnit sigmoidUnit_assertions checks (
    .clk          (clk),
    .rst          (rst),
    .startSigmoid (startSigmoid),
    .sigmoidDone  (sigmoidDone),
    .resReadEn    (resReadEn),
    .resAddr      (resAddr),
    .sigWriteEn   (sigWriteEn),
    .sigAddr      (sigAddr),
    .seqState     (seq.state)
);

/* sim/sigmoidUnitTb.sv */
`timescale 1ns/10ps

module sigmoidUnitTb;
    import sigmoidPkg::*;

    localparam int resetCycles = 8;
    localparam int tailCycles = 6;
    localparam int runWrites = numRows * sigCols;
    localparam int numRuns = 5;
    // five runs with start, recovery and tail, doubled for margin
    localparam int cycleLimit = 2 * (resetCycles + numRuns * (runWrites + tailCycles + 4));

    logic                    clk;
    logic                    rst;
    logic                    startSigmoid;
    logic [dataWidth-1:0]    resData;
    logic                    sigmoidDone;
    logic                    resReadEn;
    logic [resAddrWidth-1:0] resAddr;
    logic                    sigWriteEn;
    logic [sigAddrWidth-1:0] sigAddr;
    logic [dataWidth-1:0]    sigData;

    logic [dataWidth-1:0] resMem [numRows * resCols];
    logic [dataWidth-1:0] sigMem [runWrites];

    integer seed;
    int cycleCount = 0;
    int testErrors;
    int testsRun;
    int testsFailed;
    int totalErrors;

    sigmoidUnit DUT (
        .clk          (clk),
        .rst          (rst),
        .startSigmoid (startSigmoid),
        .resData      (resData),
        .sigmoidDone  (sigmoidDone),
        .resReadEn    (resReadEn),
        .resAddr      (resAddr),
        .sigWriteEn   (sigWriteEn),
        .sigAddr      (sigAddr),
        .sigData      (sigData)
    );

    // RES is read asynchronously
    assign resData = resMem[resAddr];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout after %0d cycles, the engine never finished its runs", cycleCount);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int sigIndexOf(input int resIndex);
        return sigCols * (resIndex / resCols) + 1 + resIndex % resCols;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
        assert (got === expected) else begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, expected);
            testErrors++;
        end
    endtask

    task automatic checkRange(input int index);
        assert (sigMem[index] >= lutMin && sigMem[index] <= lutMax) else begin
            $display("[FAIL] sig[%0d]: 0x%02h outside 0x%02h..0x%02h",
                     index, sigMem[index], lutMin, lutMax);
            testErrors++;
        end
    endtask

    task automatic checkQuiet();
        checkValue("sigWriteEn", 32'(sigWriteEn), 0);
        checkValue("resReadEn", 32'(resReadEn), 0);
        checkValue("sigmoidDone", 32'(sigmoidDone), 0);
    endtask

    task automatic checkBias();
        for (int r = 0; r < numRows; r++) begin
            checkValue($sformatf("sig[%0d]", r * sigCols), 32'(sigMem[r * sigCols]),
                       32'(biasValue));
        end
    endtask

    task automatic checkFraming(input int firstAddr, input int writes, input int dones);
        checkValue("first sigAddr", firstAddr, 0);
        checkValue("sigWriteEn count", writes, runWrites);
        checkValue("sigmoidDone count", dones, 1);
    endtask

    task automatic endTest(input string name);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, testErrors);
            testsFailed++;
            totalErrors += testErrors;
        end
    endtask

    task automatic sampleOutputs(inout int writes, inout int firstAddr, inout int dones);
        if (sigWriteEn) begin
            if (writes == 0) begin
                firstAddr = int'(sigAddr);
            end
            sigMem[sigAddr] = sigData;
            writes++;
        end
        if (sigmoidDone) begin
            dones++;
        end
    endtask

    // one start pulse, optional extra starts mid-run and in the recovery cycle
    task automatic runEngine(input int midStart, input bit startInRecovery,
                             output int firstAddr, output int writes, output int dones);
        int cycles;
        writes = 0;
        dones = 0;
        firstAddr = -1;
        cycles = 0;
        for (int a = 0; a < runWrites; a++) begin
            sigMem[a] = 8'(a) ^ 8'h80;
        end
        @(posedge clk);
        startSigmoid <= 1'b1;
        @(posedge clk);
        startSigmoid <= 1'b0;
        while (dones == 0) begin
            @(posedge clk);
            sampleOutputs(writes, firstAddr, dones);
            cycles++;
            startSigmoid <= (midStart > 0 && cycles == midStart) || (startInRecovery && dones > 0);
        end
        repeat (tailCycles) begin
            @(posedge clk);
            sampleOutputs(writes, firstAddr, dones);
            startSigmoid <= 1'b0;
        end
    endtask

    task automatic testResetQuiet();
        testErrors = 0;
        for (int i = 0; i < resetCycles; i++) begin
            @(posedge clk);
            if (i > 0) begin
                checkQuiet();
            end
        end
        rst <= 1'b0;
        repeat (tailCycles) begin
            @(posedge clk);
            checkQuiet();
        end
        endTest("reset quiet");
    endtask

    task automatic testRamp();
        int firstAddr;
        int writes;
        int dones;
        logic [dataWidth-1:0] prev;
        testErrors = 0;
        for (int a = 0; a < numRows * resCols; a++) begin
            resMem[a] <= 8'(a * 2);
        end
        runEngine(0, 1'b0, firstAddr, writes, dones);
        checkFraming(firstAddr, writes, dones);
        checkBias();
        prev = lutMin;
        for (int a = 0; a < runWrites; a++) begin
            if (a % sigCols != 0) begin
                checkRange(a);
                assert (sigMem[a] >= prev) else begin
                    $display("[FAIL] sig[%0d]: 0x%02h below previous 0x%02h", a, sigMem[a], prev);
                    testErrors++;
                end
                prev = sigMem[a];
            end
        end
        endTest("ramp run");
    endtask

    task automatic testAnchors();
        int anchorPos [6];
        int anchorScore [6];
        int anchorAct [6];
        int firstAddr;
        int writes;
        int dones;
        testErrors = 0;
        anchorPos = '{0, 37, 64, 91, 126, 127};
        anchorScore = '{0, 83, 128, 177, 255, 254};
        anchorAct = '{12, 66, 128, 194, 243, 243};
        for (int a = 0; a < numRows * resCols; a++) begin
            resMem[a] <= 8'(a * 2 + 1);
        end
        for (int k = 0; k < 6; k++) begin
            resMem[anchorPos[k]] <= 8'(anchorScore[k]);
        end
        runEngine(0, 1'b0, firstAddr, writes, dones);
        checkFraming(firstAddr, writes, dones);
        for (int k = 0; k < 6; k++) begin
            checkValue($sformatf("sig[%0d]", sigIndexOf(anchorPos[k])),
                       32'(sigMem[sigIndexOf(anchorPos[k])]), anchorAct[k]);
        end
        endTest("anchor values");
    endtask

    task automatic testRandom();
        int firstAddr;
        int writes;
        int dones;
        logic [dataWidth-1:0] actI;
        logic [dataWidth-1:0] actJ;
        testErrors = 0;
        for (int a = 0; a < numRows * resCols; a++) begin
            resMem[a] <= 8'($random(seed));
        end
        runEngine(0, 1'b0, firstAddr, writes, dones);
        checkFraming(firstAddr, writes, dones);
        checkBias();
        for (int i = 0; i < numRows * resCols; i++) begin
            checkRange(sigIndexOf(i));
            actI = sigMem[sigIndexOf(i)];
            for (int j = 0; j < numRows * resCols; j++) begin
                actJ = sigMem[sigIndexOf(j)];
                if (resMem[i] == resMem[j]) begin
                    assert (actI == actJ) else begin
                        $display("[FAIL] sig[%0d]: 0x%02h differs from sig[%0d] 0x%02h, score 0x%02h",
                                 sigIndexOf(i), actI, sigIndexOf(j), actJ, resMem[i]);
                        testErrors++;
                    end
                end else if (resMem[i] < resMem[j]) begin
                    assert (actI <= actJ) else begin
                        $display("[FAIL] sig[%0d]: 0x%02h above sig[%0d] 0x%02h for a smaller score",
                                 sigIndexOf(i), actI, sigIndexOf(j), actJ);
                        testErrors++;
                    end
                end
            end
        end
        endTest("random contents");
    endtask

    task automatic testFraming();
        int firstAddr;
        int writes;
        int dones;
        testErrors = 0;
        // extra starts while busy and during recovery
        runEngine(runWrites / 2, 1'b1, firstAddr, writes, dones);
        checkFraming(firstAddr, writes, dones);
        runEngine(0, 1'b0, firstAddr, writes, dones);
        checkFraming(firstAddr, writes, dones);
        checkBias();
        endTest("run framing");
    endtask

    initial begin
        rst = 1'b1;
        startSigmoid = 1'b0;
        seed = 32'ha0e9f5db;
        testsRun = 0;
        testsFailed = 0;
        totalErrors = 0;
        for (int a = 0; a < numRows * resCols; a++) begin
            resMem[a] = 8'(a * 2);
        end
        testResetQuiet();
        testRamp();
        testAnchors();
        testRandom();
        testFraming();
        $display("tests run %0d, failed %0d, value errors %0d, protocol assertion failures %0d",
                 testsRun, testsFailed, totalErrors, DUT.checks.assertFailures);
        if (testsFailed == 0 && DUT.checks.assertFailures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
design/sigmoidPkg.sv
design/sigmoidLut.sv
design/sigmoidSequencer.sv
design/sigmoidUnit.sv
sim/sigmoidUnit_assertions.sv
sim/sigmoidUnitTb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= sigmoidUnitTb
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Result: PASSED
VFLAGS     ?= --timing --assert --timescale 1ns/10ps
LINT_FLAGS ?= --lint-only

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
